/* Makefile */
# Verilator build and run of the DLLP generator testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f project.f --top-module tb_dllp_gen \
		-o tb_dllp_gen

run: compile
	./obj_dir/tb_dllp_gen | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dllp_active_seq.sv */
`timescale 1ns/1ns

module dllp_active_seq (
    input  logic                  sclk,
    input  logic                  arst_n_i,
    input  dllp_pkg::link_state_t link_state_i,
    input  logic [11:0]           cc_p_h_i,
    input  logic [11:0]           cc_p_d_i,
    input  logic [11:0]           cc_np_h_i,
    input  logic [11:0]           cc_np_d_i,
    input  logic [11:0]           cc_cpl_h_i,
    input  logic [11:0]           cc_cpl_d_i,
    input  logic                  nak_scheduled_i,
    input  dllp_pkg::seq_num_t    next_rcv_seq_i,
    input  logic                  arb_ready_i,
    output dllp_pkg::dllp_body_t  body_o,
    output logic                  valid_o
);
    import dllp_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        BUILD_FC_P,
        SEND_FC_P,
        BUILD_FC_NP,
        SEND_FC_NP,
        BUILD_FC_CPL,
        SEND_FC_CPL,
        BUILD_AN,
        SEND_AN,
        WAIT
    } state_t;

    state_t               state_q;
    logic [GAP_CNT_W-1:0] gap_cnt_q;
    dllp_body_t           body_q;
    hdr_credit_t          p_h_q;
    hdr_credit_t          np_h_q;
    hdr_credit_t          cpl_h_q;
    data_credit_t         p_d_q;
    data_credit_t         np_d_q;
    data_credit_t         cpl_d_q;
    logic                 nak_q;
    seq_num_t             seq_q;
    logic                 in_active;
    logic                 accept;

    assign in_active = (link_state_i == LINK_ACTIVE);
    assign valid_o   = in_active &&
                       (state_q inside {SEND_FC_P, SEND_FC_NP, SEND_FC_CPL, SEND_AN});
    assign body_o    = valid_o ? body_q : '0;
    assign accept    = valid_o && arb_ready_i;

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= IDLE;
            gap_cnt_q <= '0;
        end else if (!in_active) begin
            state_q   <= IDLE;
            gap_cnt_q <= '0;
        end else begin
            case (state_q)
                IDLE:         state_q <= BUILD_FC_P;
                BUILD_FC_P:   state_q <= SEND_FC_P;
                SEND_FC_P:    if (accept) state_q <= BUILD_FC_NP;
                BUILD_FC_NP:  state_q <= SEND_FC_NP;
                SEND_FC_NP:   if (accept) state_q <= BUILD_FC_CPL;
                BUILD_FC_CPL: state_q <= SEND_FC_CPL;
                SEND_FC_CPL:  if (accept) state_q <= BUILD_AN;
                BUILD_AN:     state_q <= SEND_AN;
                SEND_AN:      if (accept) state_q <= WAIT;
                WAIT: begin
                    if (gap_cnt_q == GAP_CNT_W'(REPEAT_GAP)) begin
                        gap_cnt_q <= '0;
                        state_q   <= IDLE;    // Resample before the next round
                    end else begin
                        gap_cnt_q <= gap_cnt_q + 1'b1;
                    end
                end
                default:      state_q <= IDLE;
            endcase
        end
    end

    // Snapshot of consumed credits and Ack/Nak info, one per round
    always_ff @(posedge sclk) begin
        if (state_q == IDLE && in_active) begin
            p_h_q   <= cc_p_h_i[7:0];
            p_d_q   <= cc_p_d_i;
            np_h_q  <= cc_np_h_i[7:0];
            np_d_q  <= cc_np_d_i;
            cpl_h_q <= cc_cpl_h_i[7:0];
            cpl_d_q <= cc_cpl_d_i;
            nak_q   <= nak_scheduled_i;
            seq_q   <= next_rcv_seq_i;
        end
    end

    always_ff @(posedge sclk) begin
        case (state_q)
            BUILD_FC_P:   body_q <= make_fc_body(TYPE_UPDATEFC_P, p_h_q, p_d_q);
            BUILD_FC_NP:  body_q <= make_fc_body(TYPE_UPDATEFC_NP, np_h_q, np_d_q);
            BUILD_FC_CPL: body_q <= make_fc_body(TYPE_UPDATEFC_CPL, cpl_h_q, cpl_d_q);
            BUILD_AN:     body_q <= {nak_q ? TYPE_NAK : TYPE_ACK, 12'd0, seq_q};
            default:      body_q <= body_q;
        endcase
    end

endmodule

/* dllp_crc16.sv */
`timescale 1ns/1ns

module dllp_crc16 (
    input  dllp_pkg::dllp_body_t body_i,
    output dllp_pkg::crc16_t     crc_o
);
    import dllp_pkg::*;

    crc16_t crc_r;

    // Bit-serial LFSR unrolled, MSB of the body goes in first
    always_comb begin
        crc_r = CRC_INIT;
        for (int i = 31; i >= 0; i--) begin
            if (crc_r[15] ^ body_i[i]) begin
                crc_r = {crc_r[14:0], 1'b0} ^ CRC_POLY;
            end else begin
                crc_r = {crc_r[14:0], 1'b0};
            end
        end
    end

    assign crc_o = ~crc_r;    // Sent inverted

endmodule

/* dllp_fc_init_seq.sv */
`timescale 1ns/1ns

module dllp_fc_init_seq (
    input  logic                  sclk,
    input  logic                  arst_n_i,
    input  dllp_pkg::link_state_t link_state_i,
    output dllp_pkg::dllp_body_t  body_o,
    output logic                  valid_o,
    input  logic                  arb_ready_i,
    output logic                  init1_done_o,
    output logic                  init2_done_o
);
    import dllp_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        BUILD_P,
        SEND_P,
        BUILD_NP,
        SEND_NP,
        BUILD_CPL,
        SEND_CPL,
        WAIT
    } state_t;

    state_t               state_q;
    link_state_t          phase_q;    // Link state seen at the previous edge
    logic [GAP_CNT_W-1:0] gap_cnt_q;
    logic                 init1_done_q;
    logic                 init2_done_q;
    dllp_body_t           body_q;
    logic                 in_init;
    logic                 in_phase;
    logic                 is_init2;
    logic                 accept;

    assign in_init  = (link_state_i == LINK_INIT1) || (link_state_i == LINK_INIT2);
    assign in_phase = in_init && (link_state_i == phase_q);
    assign is_init2 = (link_state_i == LINK_INIT2);

    // A pending DLLP is withdrawn as soon as the phase changes
    assign valid_o = in_phase && (state_q inside {SEND_P, SEND_NP, SEND_CPL});
    assign body_o  = valid_o ? body_q : '0;
    assign accept  = valid_o && arb_ready_i;

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= IDLE;
            phase_q   <= LINK_INACTIVE;
            gap_cnt_q <= '0;
        end else begin
            phase_q <= link_state_i;
            if (!in_phase) begin
                // Entering or switching phase restarts at P
                state_q   <= in_init ? BUILD_P : IDLE;
                gap_cnt_q <= '0;
            end else begin
                case (state_q)
                    IDLE:      state_q <= BUILD_P;
                    BUILD_P:   state_q <= SEND_P;
                    SEND_P:    if (accept) state_q <= BUILD_NP;
                    BUILD_NP:  state_q <= SEND_NP;
                    SEND_NP:   if (accept) state_q <= BUILD_CPL;
                    BUILD_CPL: state_q <= SEND_CPL;
                    SEND_CPL:  if (accept) state_q <= WAIT;
                    WAIT: begin
                        if (gap_cnt_q == GAP_CNT_W'(REPEAT_GAP)) begin
                            gap_cnt_q <= '0;
                            state_q   <= BUILD_P;
                        end else begin
                            gap_cnt_q <= gap_cnt_q + 1'b1;
                        end
                    end
                    default:   state_q <= IDLE;
                endcase
            end
        end
    end

    // Done flags follow the first completed round of their own phase
    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            init1_done_q <= 1'b0;
            init2_done_q <= 1'b0;
        end else begin
            if (link_state_i != LINK_INIT1) begin
                init1_done_q <= 1'b0;
            end else if (state_q == SEND_CPL && accept) begin
                init1_done_q <= 1'b1;
            end
            if (link_state_i != LINK_INIT2) begin
                init2_done_q <= 1'b0;
            end else if (state_q == SEND_CPL && accept) begin
                init2_done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge sclk) begin
        case (state_q)
            BUILD_P:   body_q <= make_fc_body(is_init2 ? TYPE_INITFC2_P : TYPE_INITFC1_P,
                                              CREDIT_LIMIT_P_HDR, CREDIT_LIMIT_P_DATA);
            BUILD_NP:  body_q <= make_fc_body(is_init2 ? TYPE_INITFC2_NP : TYPE_INITFC1_NP,
                                              CREDIT_LIMIT_NP_HDR, CREDIT_LIMIT_NP_DATA);
            BUILD_CPL: body_q <= make_fc_body(is_init2 ? TYPE_INITFC2_CPL : TYPE_INITFC1_CPL,
                                              CREDIT_LIMIT_CPL_HDR, CREDIT_LIMIT_CPL_DATA);
            default:   body_q <= body_q;
        endcase
    end

    assign init1_done_o = init1_done_q;
    assign init2_done_o = init2_done_q;

endmodule

/* dllp_framer.sv */
`timescale 1ns/1ns

module dllp_framer (
    input  dllp_pkg::dllp_body_t fc_body_i,
    input  logic                 fc_valid_i,
    input  dllp_pkg::dllp_body_t act_body_i,
    input  logic                 act_valid_i,
    output dllp_pkg::pipe_data_t dllp_data_o,
    output logic                 dllp_valid_o
);
    import dllp_pkg::*;

    dllp_body_t body;
    crc16_t     crc;

    // Idle sequencers drive zero, so OR is enough to merge
    assign body         = fc_body_i | act_body_i;
    assign dllp_valid_o = fc_valid_i | act_valid_i;

    dllp_crc16 u_crc (
        .body_i (body),
        .crc_o  (crc)
    );

    // SDP in the low lane, then CRC, then the body
    assign dllp_data_o = dllp_valid_o ? {192'd0, body, crc, SDP_TOKEN} : '0;

endmodule

/* dllp_gen_top.sv */
`timescale 1ns/1ns

module dllp_gen_top (
    input  logic                  sclk,
    input  logic                  arst_n_i,
    input  dllp_pkg::link_state_t link_state_i,
    input  logic [11:0]           cc_p_h_i,
    input  logic [11:0]           cc_p_d_i,
    input  logic [11:0]           cc_np_h_i,
    input  logic [11:0]           cc_np_d_i,
    input  logic [11:0]           cc_cpl_h_i,
    input  logic [11:0]           cc_cpl_d_i,
    input  logic                  nak_scheduled_i,
    input  dllp_pkg::seq_num_t    next_rcv_seq_i,
    input  logic                  arb_ready_i,
    output dllp_pkg::pipe_data_t  dllp_data_o,
    output logic                  dllp_valid_o,
    output logic                  init1_done_o,
    output logic                  init2_done_o
);
    import dllp_pkg::*;

    dllp_body_t fc_body;
    logic       fc_valid;
    dllp_body_t act_body;
    logic       act_valid;

    dllp_fc_init_seq u_fc_init_seq (
        .sclk         (sclk),
        .arst_n_i     (arst_n_i),
        .link_state_i (link_state_i),
        .body_o       (fc_body),
        .valid_o      (fc_valid),
        .arb_ready_i  (arb_ready_i),
        .init1_done_o (init1_done_o),
        .init2_done_o (init2_done_o)
    );

    dllp_active_seq u_active_seq (
        .sclk            (sclk),
        .arst_n_i        (arst_n_i),
        .link_state_i    (link_state_i),
        .cc_p_h_i        (cc_p_h_i),
        .cc_p_d_i        (cc_p_d_i),
        .cc_np_h_i       (cc_np_h_i),
        .cc_np_d_i       (cc_np_d_i),
        .cc_cpl_h_i      (cc_cpl_h_i),
        .cc_cpl_d_i      (cc_cpl_d_i),
        .nak_scheduled_i (nak_scheduled_i),
        .next_rcv_seq_i  (next_rcv_seq_i),
        .arb_ready_i     (arb_ready_i),
        .body_o          (act_body),
        .valid_o         (act_valid)
    );

    dllp_framer u_framer (
        .fc_body_i    (fc_body),
        .fc_valid_i   (fc_valid),
        .act_body_i   (act_body),
        .act_valid_i  (act_valid),
        .dllp_data_o  (dllp_data_o),
        .dllp_valid_o (dllp_valid_o)
    );

endmodule

/* dllp_pkg.sv */
package dllp_pkg;

    // Link states reported by the DLCM
    typedef enum logic [1:0] {
        LINK_INACTIVE = 2'd0,
        LINK_INIT1    = 2'd1,
        LINK_INIT2    = 2'd2,
        LINK_ACTIVE   = 2'd3
    } link_state_t;

    typedef logic [31:0]  dllp_body_t;    // Type byte plus three payload bytes
    typedef logic [15:0]  crc16_t;
    typedef logic [255:0] pipe_data_t;
    typedef logic [7:0]   hdr_credit_t;
    typedef logic [11:0]  data_credit_t;
    typedef logic [11:0]  seq_num_t;
    typedef logic [7:0]   dllp_type_t;

    localparam dllp_type_t TYPE_INITFC1_P   = 8'h40;
    localparam dllp_type_t TYPE_INITFC1_NP  = 8'h50;
    localparam dllp_type_t TYPE_INITFC1_CPL = 8'h60;
    localparam dllp_type_t TYPE_INITFC2_P   = 8'hC0;
    localparam dllp_type_t TYPE_INITFC2_NP  = 8'hD0;
    localparam dllp_type_t TYPE_INITFC2_CPL = 8'hE0;
    localparam dllp_type_t TYPE_UPDATEFC_P   = 8'h80;
    localparam dllp_type_t TYPE_UPDATEFC_NP  = 8'h90;
    localparam dllp_type_t TYPE_UPDATEFC_CPL = 8'hA0;
    localparam dllp_type_t TYPE_ACK          = 8'h00;
    localparam dllp_type_t TYPE_NAK          = 8'h10;

    localparam logic [15:0] SDP_TOKEN = 16'hACF0;    // Start of DLLP framing token

    localparam crc16_t CRC_POLY = 16'h100B;
    localparam crc16_t CRC_INIT = 16'hFFFF;

    // Advertised receive buffer limits, VC0 only
    localparam hdr_credit_t  CREDIT_LIMIT_P_HDR    = 8'd16;
    localparam hdr_credit_t  CREDIT_LIMIT_NP_HDR   = 8'd16;
    localparam hdr_credit_t  CREDIT_LIMIT_CPL_HDR  = 8'd16;
    localparam data_credit_t CREDIT_LIMIT_P_DATA   = 12'd16;
    localparam data_credit_t CREDIT_LIMIT_NP_DATA  = 12'd16;
    localparam data_credit_t CREDIT_LIMIT_CPL_DATA = 12'd16;

    localparam int REPEAT_GAP = 100;                        // Pause between rounds
    localparam int GAP_CNT_W  = $clog2(REPEAT_GAP + 1);

    // Flow-control body, both scale fields fixed at zero
    function automatic dllp_body_t make_fc_body(
        input dllp_type_t   fc_type,
        input hdr_credit_t  hdr,
        input data_credit_t data
    );
        return {fc_type, 2'b00, hdr, 2'b00, data};
    endfunction

endpackage

/* project.f */
dllp_pkg.sv
dllp_crc16.sv
dllp_fc_init_seq.sv
dllp_active_seq.sv
dllp_framer.sv
dllp_gen_top.sv
tb_dllp_gen.sv

/* tb_dllp_gen.sv */
`timescale 1ns/1ns

module tb_dllp_gen;
    import dllp_pkg::*;

    localparam int INIT_ROUNDS  = 3;
    localparam int ACT_ROUNDS   = 16;
    localparam int TOTAL_ROUNDS = 2 * INIT_ROUNDS + ACT_ROUNDS + 4;    // Plus mid-round tests
    localparam int ROUND_CYC    = REPEAT_GAP + 3 + 4 * 3;   // Gap plus four sends at half rate
    localparam int CYCLE_LIMIT  = TOTAL_ROUNDS * ROUND_CYC * 4;

    logic        sclk;
    logic        arst_n_i;
    link_state_t link_state_i;
    logic [11:0] cc_p_h_i;
    logic [11:0] cc_p_d_i;
    logic [11:0] cc_np_h_i;
    logic [11:0] cc_np_d_i;
    logic [11:0] cc_cpl_h_i;
    logic [11:0] cc_cpl_d_i;
    logic        nak_scheduled_i;
    seq_num_t    next_rcv_seq_i;
    logic        arb_ready_i;
    pipe_data_t  dllp_data_o;
    logic        dllp_valid_o;
    logic        init1_done_o;
    logic        init2_done_o;

    logic [31:0] lfsr_q;
    int          cycle_cnt;
    int          idx;         // Position of the next DLLP in the round
    int          rounds;
    int          low_run;     // Cycles with valid low since the last DLLP
    int          exp_low;
    logic        pending;
    logic        reroll;
    logic        done1_exp;
    logic        done2_exp;
    logic        ack_seen;
    logic        nak_seen;

    dllp_gen_top UUT (
        .sclk            (sclk),
        .arst_n_i        (arst_n_i),
        .link_state_i    (link_state_i),
        .cc_p_h_i        (cc_p_h_i),
        .cc_p_d_i        (cc_p_d_i),
        .cc_np_h_i       (cc_np_h_i),
        .cc_np_d_i       (cc_np_d_i),
        .cc_cpl_h_i      (cc_cpl_h_i),
        .cc_cpl_d_i      (cc_cpl_d_i),
        .nak_scheduled_i (nak_scheduled_i),
        .next_rcv_seq_i  (next_rcv_seq_i),
        .arb_ready_i     (arb_ready_i),
        .dllp_data_o     (dllp_data_o),
        .dllp_valid_o    (dllp_valid_o),
        .init1_done_o    (init1_done_o),
        .init2_done_o    (init2_done_o)
    );

    always #10 sclk = ~sclk;

    always @(posedge sclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles, rounds stopped completing", cycle_cnt));
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [255:0] act, input logic [255:0] exp);
        if (act !== exp) begin
            abort_run($sformatf("error at %0t ns: %s = 0x%0h, expected 0x%0h",
                                $time, name, act, exp));
        end
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic rand_bit();
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        return lfsr_q[0];
    endfunction

    function automatic logic [11:0] rand_bits(input int n);
        logic [11:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[10:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic crc16_t crc_ref(input dllp_body_t b);
        crc16_t r;
        logic   fb;
        r = CRC_INIT;
        for (int i = 31; i >= 0; i--) begin
            fb = r[15] ^ b[i];
            r  = (r << 1) ^ (fb ? CRC_POLY : 16'h0000);
        end
        return ~r;
    endfunction

    // Inputs are stable since the round was sampled, so they stand for the snapshot
    function automatic dllp_body_t expected_body(input link_state_t ls, input int n);
        dllp_body_t b;
        logic       fc2;
        fc2 = (ls == LINK_INIT2);
        if (ls == LINK_ACTIVE) begin
            case (n)
                0:       b = {TYPE_UPDATEFC_P, 2'b00, cc_p_h_i[7:0], 2'b00, cc_p_d_i};
                1:       b = {TYPE_UPDATEFC_NP, 2'b00, cc_np_h_i[7:0], 2'b00, cc_np_d_i};
                2:       b = {TYPE_UPDATEFC_CPL, 2'b00, cc_cpl_h_i[7:0], 2'b00, cc_cpl_d_i};
                default: b = {nak_scheduled_i ? TYPE_NAK : TYPE_ACK, 12'd0, next_rcv_seq_i};
            endcase
        end else begin
            case (n)
                0:       b = {fc2 ? TYPE_INITFC2_P : TYPE_INITFC1_P, 2'b00,
                              CREDIT_LIMIT_P_HDR, 2'b00, CREDIT_LIMIT_P_DATA};
                1:       b = {fc2 ? TYPE_INITFC2_NP : TYPE_INITFC1_NP, 2'b00,
                              CREDIT_LIMIT_NP_HDR, 2'b00, CREDIT_LIMIT_NP_DATA};
                default: b = {fc2 ? TYPE_INITFC2_CPL : TYPE_INITFC1_CPL, 2'b00,
                              CREDIT_LIMIT_CPL_HDR, 2'b00, CREDIT_LIMIT_CPL_DATA};
            endcase
        end
        return b;
    endfunction

    function automatic pipe_data_t frame_word(input dllp_body_t b);
        return {192'd0, b, crc_ref(b), SDP_TOKEN};
    endfunction

    task automatic draw_inputs();
        cc_p_h_i        = rand_bits(12);
        cc_p_d_i        = rand_bits(12);
        cc_np_h_i       = rand_bits(12);
        cc_np_d_i       = rand_bits(12);
        cc_cpl_h_i      = rand_bits(12);
        cc_cpl_d_i      = rand_bits(12);
        nak_scheduled_i = rand_bit();
        next_rcv_seq_i  = rand_bits(12);
    endtask

    // Outputs settle after the inputs change and hold until the rising edge
    task automatic observe();
        logic take;
        logic round_end;
        take      = dllp_valid_o && arb_ready_i;
        round_end = take && (idx == ((link_state_i == LINK_ACTIVE) ? 3 : 2));
        check("init1_done_o", 256'(init1_done_o), 256'(done1_exp));
        check("init2_done_o", 256'(init2_done_o), 256'(done2_exp));
        if (!arst_n_i || link_state_i == LINK_INACTIVE) begin
            check("dllp_valid_o", 256'(dllp_valid_o), 256'(1'b0));
        end
        if (!dllp_valid_o) begin
            if (pending) begin
                abort_run("dllp_valid_o dropped while a DLLP was waiting for arb_ready_i");
            end
            check("dllp_data_o", dllp_data_o, '0);
            low_run++;
        end else begin
            if (!pending) begin
                check("cycles before dllp_valid_o", 256'(low_run), 256'(exp_low));
            end
            check("dllp_data_o", dllp_data_o, frame_word(expected_body(link_state_i, idx)));
            pending = !arb_ready_i;    // Same expected word until taken
            low_run = 0;
        end
        if (round_end) begin
            idx = 0;
            rounds++;
            exp_low = (link_state_i == LINK_ACTIVE) ? REPEAT_GAP + 3 : REPEAT_GAP + 2;
            if (link_state_i == LINK_ACTIVE) begin
                reroll = 1'b1;
                nak_seen = nak_seen | nak_scheduled_i;
                ack_seen = ack_seen | !nak_scheduled_i;
            end
        end else if (take) begin
            idx++;
            exp_low = 1;
        end
        done1_exp = (link_state_i == LINK_INIT1) && (done1_exp || round_end);
        done2_exp = (link_state_i == LINK_INIT2) && (done2_exp || round_end);
    endtask

    task automatic step(input logic rst_n, input link_state_t ls, input logic rdy);
        @(negedge sclk);
        arst_n_i = rst_n;
        if (ls != link_state_i) begin
            link_state_i = ls;
            idx     = 0;    // New state starts from its first DLLP
            pending = 1'b0;
            low_run = 0;
            exp_low = 2;
        end
        if (reroll) begin
            draw_inputs();
            reroll = 1'b0;
        end
        arb_ready_i = rdy;
        #1;
        observe();
    endtask

    task automatic run_rounds(input link_state_t ls, input int n);
        int target;
        target = rounds + n;
        while (rounds < target) begin
            step(1'b1, ls, rand_bit());
        end
    endtask

    // Hold the DLLP at position at_idx pending, then change the link state
    task automatic switch_mid_round(input link_state_t cur, input int at_idx,
                                    input link_state_t nxt);
        logic held;
        held = 1'b0;
        while (!held) begin
            step(1'b1, cur, (idx == at_idx) ? 1'b0 : rand_bit());
            held = pending && (idx == at_idx);
        end
        step(1'b1, nxt, rand_bit());
    endtask

    initial begin
        sclk         = 1'b0;
        arst_n_i     = 1'b0;
        link_state_i = LINK_INACTIVE;
        arb_ready_i  = 1'b0;
        lfsr_q       = 32'hbd98_f6af;
        cycle_cnt    = 0;
        idx          = 0;
        rounds       = 0;
        low_run      = 0;
        exp_low      = 2;
        pending      = 1'b0;
        reroll       = 1'b0;
        done1_exp    = 1'b0;
        done2_exp    = 1'b0;
        ack_seen     = 1'b0;
        nak_seen     = 1'b0;
        draw_inputs();
        repeat (3) step(1'b0, LINK_INACTIVE, rand_bit());
        repeat (6) step(1'b1, LINK_INACTIVE, rand_bit());
        run_rounds(LINK_INIT1, INIT_ROUNDS);
        run_rounds(LINK_INIT2, INIT_ROUNDS);
        run_rounds(LINK_ACTIVE, ACT_ROUNDS);
        switch_mid_round(LINK_ACTIVE, 2, LINK_INIT1);
        run_rounds(LINK_INIT1, 1);
        switch_mid_round(LINK_INIT1, 1, LINK_INIT2);
        run_rounds(LINK_INIT2, 1);
        switch_mid_round(LINK_INIT2, 0, LINK_ACTIVE);
        run_rounds(LINK_ACTIVE, 2);
        repeat (6) step(1'b1, LINK_INACTIVE, rand_bit());
        if (rounds == TOTAL_ROUNDS && ack_seen && nak_seen) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d of %0d rounds completed, Ack seen %0b, Nak seen %0b",
                                rounds, TOTAL_ROUNDS, ack_seen, nak_seen));
        end
    end

endmodule
